/* fp_format_pkg.sv */
package fp_format_pkg;

    // binary32 field widths
    localparam int EXP_W  = 8;
    localparam int FRAC_W = 23;
    localparam int BIAS   = 127;

    // 24x24 significand product
    localparam int PROD_W = 48;

    // hidden bit, 23 fraction bits, guard, round, sticky
    localparam int NORM_W = 27;

    localparam logic [31:0] QNAN = 32'h7fc0_0000;

    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exp;
        logic [FRAC_W-1:0] frac;
    } fp32_t;

    // class of the result, settled in stage 1
    typedef enum logic [1:0] {
        normal = 2'd0,
        zero   = 2'd1,
        inf    = 2'd2,
        nan    = 2'd3
    } fp_class_e;

endpackage

/* fp_mul_pkg.sv */
package fp_mul_pkg;

    // codes 5 to 7 are left unnamed and truncate like rtz
    typedef enum logic [2:0] {
        rne = 3'd0,
        rtz = 3'd1,
        rdn = 3'd2,
        rup = 3'd3,
        rmm = 3'd4
    } round_mode_e;

    typedef struct packed {
        logic [fp_format_pkg::PROD_W-1:0] frc_z_full;
        logic signed [9:0]                exp_sum;
        logic                             sign_z;
        fp_format_pkg::fp_class_e         cls;
        round_mode_e                      r_mode;
    } prod_t;

    typedef struct packed {
        fp_format_pkg::fp32_t fp_z;
        logic                 ovrf;
        logic                 udrf;
    } result_t;

endpackage

/* fp_stage_if.sv */
`timescale 1ns/1ps

interface fp_stage_if #(
    parameter type payload_t = logic [31:0]
);

    logic     valid;
    logic     ready;
    payload_t payload;

    // producer side
    modport src (
        output valid,
        output payload,
        input  ready
    );

    // consumer side
    modport dst (
        input  valid,
        input  payload,
        output ready
    );

endinterface

/* fp_pipe_reg.sv */
`timescale 1ns/1ps

module fp_pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic    clk,
    input  logic    rst_n,
    fp_stage_if.dst up,
    fp_stage_if.src down
);

    logic     full;
    payload_t data;

    // take a new item while the held one leaves
    assign up.ready     = !full || down.ready;
    assign down.valid   = full;
    assign down.payload = data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (up.ready) begin
            full <= up.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (up.valid && up.ready) begin
            data <= up.payload;
        end
    end

    // stalled output must not move
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (down.valid && !down.ready) |=> (down.valid && $stable(down.payload)));

endmodule

/* fp_frac_mul.sv */
`timescale 1ns/1ps

module fp_frac_mul (
    input  fp_format_pkg::fp32_t    fp_x,
    input  fp_format_pkg::fp32_t    fp_y,
    input  fp_mul_pkg::round_mode_e r_mode,
    input  logic                    in_valid,
    output logic                    in_ready,
    fp_stage_if.src                 prod
);

    import fp_format_pkg::*;

    logic                    x_zero;
    logic                    x_inf;
    logic                    x_nan;
    logic                    y_zero;
    logic                    y_inf;
    logic                    y_nan;
    logic [FRAC_W:0]         sig_x;
    logic [FRAC_W:0]         sig_y;
    logic [FRAC_W+3:0]       mplier;
    logic signed [PROD_W+1:0] mcand;
    logic signed [PROD_W+1:0] pp;
    logic signed [PROD_W+1:0] acc;
    logic [9:0]              exp_sum;
    fp_class_e               cls;

    // zero exponent covers subnormals too, they flush to zero
    assign x_zero = (fp_x.exp == '0);
    assign x_inf  = (fp_x.exp == '1) && (fp_x.frac == '0);
    assign x_nan  = (fp_x.exp == '1) && (fp_x.frac != '0);
    assign y_zero = (fp_y.exp == '0);
    assign y_inf  = (fp_y.exp == '1) && (fp_y.frac == '0);
    assign y_nan  = (fp_y.exp == '1) && (fp_y.frac != '0);

    assign sig_x = x_zero ? '0 : {1'b1, fp_x.frac};
    assign sig_y = y_zero ? '0 : {1'b1, fp_y.frac};

    always_comb begin
        if (x_nan || y_nan || (x_inf && y_zero) || (y_inf && x_zero)) begin
            cls = nan;
        end else if (x_inf || y_inf) begin
            cls = inf;
        end else if (x_zero || y_zero) begin
            cls = zero;
        end else begin
            cls = normal;
        end
    end

    // radix-4 booth, 13 digits over the zero-padded multiplier
    assign mcand  = $signed({{(PROD_W - FRAC_W + 1){1'b0}}, sig_x});
    assign mplier = {2'b00, sig_y, 1'b0};

    always_comb begin
        acc = '0;
        for (int i = 0; i < (FRAC_W + 3) / 2; i++) begin
            case (mplier[2*i +: 3])
                3'b001, 3'b010: pp = mcand;
                3'b011:         pp = mcand <<< 1;
                3'b100:         pp = -(mcand <<< 1);
                3'b101, 3'b110: pp = -mcand;
                default:        pp = '0;
            endcase
            acc = acc + (pp <<< (2 * i));
        end
    end

    assign exp_sum = 10'({2'b00, fp_x.exp} + {2'b00, fp_y.exp} - BIAS);

    assign prod.valid   = in_valid;
    assign in_ready     = prod.ready;
    assign prod.payload = '{
        frc_z_full: acc[PROD_W-1:0],
        exp_sum:    exp_sum,
        sign_z:     fp_x.sign ^ fp_y.sign,
        cls:        cls,
        r_mode:     r_mode
    };

endmodule

/* fp_exp_pack.sv */
`timescale 1ns/1ps

module fp_exp_pack (
    input  logic [9:0]               exp_adj,
    input  logic                     sign_z,
    input  logic [22:0]              frc_z,
    input  fp_format_pkg::fp_class_e cls,
    fp_stage_if.src                  res,
    input  logic                     valid_in,
    output logic                     ready_out
);

    import fp_format_pkg::*;

    logic signed [9:0] exp_s;
    fp32_t             z;
    logic              ovf;
    logic              udf;

    assign exp_s = exp_adj;

    always_comb begin
        ovf = 1'b0;
        udf = 1'b0;
        case (cls)
            nan:  z = QNAN;
            inf:  z = '{sign: sign_z, exp: '1, frac: '0};
            zero: z = '{sign: sign_z, exp: '0, frac: '0};
            default: begin
                // no subnormal results, out of range goes to inf or zero
                if (exp_s >= 10'sd255) begin
                    ovf = 1'b1;
                    z   = '{sign: sign_z, exp: '1, frac: '0};
                end else if (exp_s <= 10'sd0) begin
                    udf = 1'b1;
                    z   = '{sign: sign_z, exp: '0, frac: '0};
                end else begin
                    z = '{sign: sign_z, exp: exp_adj[EXP_W-1:0], frac: frc_z};
                end
            end
        endcase
    end

    assign res.valid   = valid_in;
    assign ready_out   = res.ready;
    assign res.payload = '{fp_z: z, ovrf: ovf, udrf: udf};

    always_comb begin
        a_flags_excl: assert final (!(res.valid && res.payload.ovrf && res.payload.udrf));
    end

endmodule

/* fp_norm_round.sv */
`timescale 1ns/1ps

module fp_norm_round (
    fp_stage_if.dst                  prod,
    output logic [26:0]              frc_z_norm,
    output logic                     norm_n,
    output logic                     norm_r,
    output logic [22:0]              frc_z,
    output logic [9:0]               exp_adj,
    output logic                     sign_z,
    output fp_format_pkg::fp_class_e cls,
    fp_stage_if.src                  res
);

    import fp_format_pkg::*;
    import fp_mul_pkg::*;

    logic [PROD_W-1:0] p;
    logic              lsb;
    logic              guard;
    logic              rest;
    logic              inexact;
    logic              inc;
    logic [FRAC_W:0]   frac_rnd;

    assign p      = prod.payload.frc_z_full;
    assign sign_z = prod.payload.sign_z;
    assign cls    = prod.payload.cls;

    // product lies in [1,4), bit 47 marks the upper half
    assign norm_n     = p[PROD_W-1];
    assign frc_z_norm = norm_n ? {p[47:22], |p[21:0]} : {p[46:21], |p[20:0]};

    assign lsb     = frc_z_norm[3];
    assign guard   = frc_z_norm[2];
    assign rest    = |frc_z_norm[1:0];
    assign inexact = guard || rest;

    always_comb begin
        case (prod.payload.r_mode)
            rne:     inc = guard && (rest || lsb);
            rdn:     inc = sign_z && inexact;
            rup:     inc = !sign_z && inexact;
            rmm:     inc = guard;
            default: inc = 1'b0;
        endcase
    end

    // carry out of the fraction means 10.000..., fraction wraps to zero
    assign frac_rnd = {1'b0, frc_z_norm[NORM_W-2:3]} + {{FRAC_W{1'b0}}, inc};
    assign norm_r   = frac_rnd[FRAC_W];
    assign frc_z    = frac_rnd[FRAC_W-1:0];

    assign exp_adj = prod.payload.exp_sum + {9'b0, norm_n} + {9'b0, norm_r};

    fp_exp_pack u_pack (
        .exp_adj   (exp_adj),
        .sign_z    (sign_z),
        .frc_z     (frc_z),
        .cls       (cls),
        .res       (res),
        .valid_in  (prod.valid),
        .ready_out (prod.ready)
    );

    // a normal class from stage 1 must carry a nonzero leading bit
    always_comb begin
        a_norm_msb: assert final (!(prod.valid && cls == normal) || frc_z_norm[NORM_W-1]);
    end

endmodule

/* fp_mul_checker.sv */
`timescale 1ns/1ps

module fp_mul_checker (
    // stage 1
    input logic                     s1_valid,
    input logic [31:0]              fp_x,
    input logic [31:0]              fp_y,
    input logic [47:0]              frc_z_full,
    // stage 2
    input logic                     s2_valid,
    input fp_mul_pkg::round_mode_e  r_mode,
    input fp_format_pkg::fp_class_e cls,
    input logic [47:0]              frc_z_reg,
    input logic [26:0]              frc_z_norm,
    input logic                     norm_n,
    input logic                     norm_r,
    input logic                     sign_z,
    input logic [22:0]              frc_z,
    input logic [9:0]               exp_z,
    input logic [31:0]              fp_z,
    input logic                     ovrf,
    input logic                     udrf
);

    import fp_format_pkg::*;
    import fp_mul_pkg::*;

    logic        x_norm;
    logic        y_norm;
    logic [47:0] prod_ref;
    logic [47:0] prod_shift;
    logic [22:0] trunc;
    logic        half;
    logic        below;
    logic [23:0] trunc_ext;
    logic [23:0] trunc_inc;

    always_comb begin
        x_norm   = (fp_x[30:23] != 8'h00) && (fp_x[30:23] != 8'hff);
        y_norm   = (fp_y[30:23] != 8'h00) && (fp_y[30:23] != 8'hff);
        prod_ref = {1'b1, fp_x[22:0]} * {1'b1, fp_y[22:0]};

        // rounding rebuilt from the raw product, not from frc_z_norm
        prod_shift = frc_z_reg[47] ? frc_z_reg : {frc_z_reg[46:0], 1'b0};
        trunc      = prod_shift[46:24];
        half       = prod_shift[23];
        below      = |prod_shift[22:0];
        trunc_ext  = {1'b0, trunc};
        trunc_inc  = trunc_ext + 24'd1;

        if (s1_valid) begin
            booth_prod: assert ((x_norm && y_norm) -> (frc_z_full == prod_ref));
        end

        if (s2_valid) begin
            norm_shift: assert ((frc_z_norm[26:1] == prod_shift[47:22])
                                && (frc_z_norm[0] == |prod_shift[21:0])
                                && (norm_n == frc_z_reg[47]));

            round_rne: assert ((r_mode == rne) -> ({norm_r, frc_z} ==
                               ((half && (below || trunc[0])) ? trunc_inc : trunc_ext)));
            round_rdn: assert ((r_mode == rdn) -> ({norm_r, frc_z} ==
                               ((sign_z && (half || below)) ? trunc_inc : trunc_ext)));
            round_rup: assert ((r_mode == rup) -> ({norm_r, frc_z} ==
                               ((!sign_z && (half || below)) ? trunc_inc : trunc_ext)));
            round_rmm: assert ((r_mode == rmm) -> ({norm_r, frc_z} ==
                               (half ? trunc_inc : trunc_ext)));
            // rtz and the spare codes
            round_rtz: assert (!(r_mode inside {rne, rdn, rup, rmm}) ->
                               ({norm_r, frc_z} == trunc_ext));

            pack_sign: assert ((cls != nan) -> (fp_z[31] == sign_z));
            pack_norm: assert ((cls == normal && !ovrf && !udrf) ->
                               (fp_z == {sign_z, exp_z[7:0], frc_z}));
            pack_ovrf: assert (ovrf -> (($signed(exp_z) >= 255)
                                        && (fp_z[30:0] == 31'h7f80_0000)));
            pack_udrf: assert (udrf -> (($signed(exp_z) <= 0) && (fp_z[30:0] == 31'h0)));
        end
    end

endmodule

/* fp_mul_top.sv */
`timescale 1ns/1ps

module fp_mul_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    output logic        in_ready,
    input  logic [31:0] fp_x,
    input  logic [31:0] fp_y,
    input  logic [2:0]  r_mode,
    output logic        out_valid,
    input  logic        out_ready,
    output logic [31:0] fp_z,
    output logic        ovrf,
    output logic        udrf
);

    import fp_format_pkg::*;
    import fp_mul_pkg::*;

    fp_stage_if #(.payload_t(prod_t))   s1_in  ();
    fp_stage_if #(.payload_t(prod_t))   s1_out ();
    fp_stage_if #(.payload_t(result_t)) s2_in  ();
    fp_stage_if #(.payload_t(result_t)) s2_out ();

    logic [NORM_W-1:0] frc_z_norm;
    logic              norm_n;
    logic              norm_r;
    logic [FRAC_W-1:0] frc_z;
    logic [9:0]        exp_adj;
    logic              sign_z;
    fp_class_e         cls;

    fp_frac_mul u_frac_mul (
        .fp_x     (fp_x),
        .fp_y     (fp_y),
        .r_mode   (round_mode_e'(r_mode)),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .prod     (s1_in)
    );

    fp_pipe_reg #(.payload_t(prod_t)) u_reg1 (
        .clk   (clk),
        .rst_n (rst_n),
        .up    (s1_in),
        .down  (s1_out)
    );

    fp_norm_round u_norm_round (
        .prod       (s1_out),
        .frc_z_norm (frc_z_norm),
        .norm_n     (norm_n),
        .norm_r     (norm_r),
        .frc_z      (frc_z),
        .exp_adj    (exp_adj),
        .sign_z     (sign_z),
        .cls        (cls),
        .res        (s2_in)
    );

    fp_pipe_reg #(.payload_t(result_t)) u_reg2 (
        .clk   (clk),
        .rst_n (rst_n),
        .up    (s2_in),
        .down  (s2_out)
    );

    assign out_valid    = s2_out.valid;
    assign s2_out.ready = out_ready;
    assign fp_z         = s2_out.payload.fp_z;
    assign ovrf         = s2_out.payload.ovrf;
    assign udrf         = s2_out.payload.udrf;

    fp_mul_checker u_checker (
        .s1_valid   (in_valid),
        .fp_x       (fp_x),
        .fp_y       (fp_y),
        .frc_z_full (s1_in.payload.frc_z_full),
        .s2_valid   (s1_out.valid),
        .r_mode     (s1_out.payload.r_mode),
        .cls        (cls),
        .frc_z_reg  (s1_out.payload.frc_z_full),
        .frc_z_norm (frc_z_norm),
        .norm_n     (norm_n),
        .norm_r     (norm_r),
        .sign_z     (sign_z),
        .frc_z      (frc_z),
        .exp_z      (exp_adj),
        .fp_z       (s2_in.payload.fp_z),
        .ovrf       (s2_in.payload.ovrf),
        .udrf       (s2_in.payload.udrf)
    );

endmodule

/* tb_fp_mul.sv */
`timescale 1ns/1ps

module tb_fp_mul;

    localparam int TIMEOUT = 1000;

    typedef struct packed {
        logic [31:0] x;
        logic [31:0] y;
        logic [2:0]  mode;
        logic [31:0] cyc;
    } item_t;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic        in_ready;
    logic [31:0] fp_x;
    logic [31:0] fp_y;
    logic [2:0]  r_mode;
    logic        out_valid;
    logic        out_ready;
    logic [31:0] fp_z;
    logic        ovrf;
    logic        udrf;

    integer      seed;
    logic        stall_en;
    logic [31:0] cyc;
    int          n_in;
    int          n_out;
    item_t       pend[$];

    fp_mul_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .fp_x      (fp_x),
        .fp_y      (fp_y),
        .r_mode    (r_mode),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .fp_z      (fp_z),
        .ovrf      (ovrf),
        .udrf      (udrf)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic stop_on_error();
        $display("Simulation failed");
        $fatal(1, "run aborted after a failed check");
    endtask

    // expected {fp_z, ovrf, udrf} from the unrounded product
    function automatic logic [33:0] ref_fp_mul(input logic [31:0] x, input logic [31:0] y,
                                               input logic [2:0] mode);
        logic        sz;
        logic [7:0]  ex;
        logic [7:0]  ey;
        logic [22:0] fx;
        logic [22:0] fy;
        logic [47:0] p;
        logic [23:0] mant;
        logic        g;
        logic        st;
        logic        up;
        logic [24:0] mr;
        int          e;
        sz = x[31] ^ y[31];
        ex = x[30:23];
        ey = y[30:23];
        fx = x[22:0];
        fy = y[22:0];
        if ((ex == 8'hff && fx != 0) || (ey == 8'hff && fy != 0)) return {32'h7fc0_0000, 2'b00};
        // subnormals count as zero here
        if ((ex == 8'hff && ey == 0) || (ey == 8'hff && ex == 0)) return {32'h7fc0_0000, 2'b00};
        if (ex == 8'hff || ey == 8'hff) return {sz, 8'hff, 23'h0, 2'b00};
        if (ex == 0 || ey == 0) return {sz, 31'h0, 2'b00};
        p = {24'h0, 1'b1, fx} * {24'h0, 1'b1, fy};
        e = int'(ex) + int'(ey) - 127;
        if (p[47]) begin
            mant = p[47:24];
            g    = p[23];
            st   = |p[22:0];
            e    = e + 1;
        end else begin
            mant = p[46:23];
            g    = p[22];
            st   = |p[21:0];
        end
        case (mode)
            3'd0:    up = g && (st || mant[0]);
            3'd2:    up = sz && (g || st);
            3'd3:    up = !sz && (g || st);
            3'd4:    up = g;
            default: up = 1'b0;
        endcase
        mr = {1'b0, mant} + {24'h0, up};
        if (mr[24]) begin
            e    = e + 1;
            mant = 24'h80_0000;
        end else begin
            mant = mr[23:0];
        end
        if (e >= 255) return {sz, 8'hff, 23'h0, 2'b10};
        if (e <= 0) return {sz, 31'h0, 2'b01};
        return {sz, e[7:0], mant[22:0], 2'b00};
    endfunction

    function automatic logic [31:0] rand_normal();
        logic [31:0] r;
        r = $random(seed);
        // exponents 64..191 keep most products in range
        r[30:23] = 8'd64 + {1'b0, r[29:23]};
        return r;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        if (stall_en) begin
            out_ready <= (($random(seed) & 3) != 0);
        end else begin
            out_ready <= 1'b1;
        end
    endtask

    task automatic send(input logic [31:0] x, input logic [31:0] y, input logic [2:0] mode);
        int waited;
        fp_x     <= x;
        fp_y     <= y;
        r_mode   <= mode;
        in_valid <= 1'b1;
        waited = 0;
        do begin
            next_cycle();
            waited++;
            if (waited > TIMEOUT) begin
                $display("timeout: in_ready stayed low, input was never accepted");
                stop_on_error();
            end
        end while (!in_ready);
    endtask

    task automatic send_modes(input logic [31:0] x, input logic [31:0] y);
        for (int m = 0; m < 5; m++) begin
            send(x, y, 3'(m));
        end
    endtask

    task automatic drain();
        int waited;
        in_valid <= 1'b0;
        waited = 0;
        do begin
            next_cycle();
            waited++;
            if (waited > TIMEOUT) begin
                $display("timeout: results still missing after the last input");
                stop_on_error();
            end
        end while (pend.size() != 0);
    endtask

    // scoreboard compares on every output transfer
    always @(posedge clk) begin
        item_t       it;
        logic [33:0] want;
        if (rst_n && out_valid && out_ready) begin
            assert (pend.size() > 0) else begin
                $display("an output arrived with no input pending");
                stop_on_error();
            end
            it   = pend.pop_front();
            want = ref_fp_mul(it.x, it.y, it.mode);
            n_out++;
            assert ({fp_z, ovrf, udrf} == want) else begin
                $display("[ERROR] %0t: x=%h y=%h mode=%0d got %h o=%b u=%b, expected %h o=%b u=%b",
                         $time, it.x, it.y, it.mode, fp_z, ovrf, udrf,
                         want[33:2], want[1], want[0]);
                stop_on_error();
            end
            if (!stall_en) begin
                assert (cyc - it.cyc == 32'd2) else begin
                    $display("[ERROR] %0t: latency %0d edges, expected 2", $time, cyc - it.cyc);
                    stop_on_error();
                end
            end
        end
        if (rst_n && in_valid && in_ready) begin
            pend.push_back('{x: fp_x, y: fp_y, mode: r_mode, cyc: cyc});
            n_in++;
        end
    end

    initial begin
        seed      = 32'h5968;
        clk       = 1'b0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        fp_x      = '0;
        fp_y      = '0;
        r_mode    = '0;
        out_ready = 1'b1;
        stall_en  = 1'b0;
        cyc       = '0;
        n_in      = 0;
        n_out     = 0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        next_cycle();
        assert (!out_valid && in_ready) else begin
            $display("pipeline not empty and ready after reset");
            stop_on_error();
        end

        for (int i = 0; i < 240; i++) begin
            send(rand_normal(), rand_normal(), 3'(i % 8));
        end
        // exact ties with odd and even lsb
        send_modes(32'h3f80_0001, 32'h3fc0_0000);
        send_modes(32'h3f80_0003, 32'h3fc0_0000);
        send_modes(32'hbf80_0001, 32'h3fc0_0000);
        send_modes(32'hbf80_0003, 32'h3fc0_0000);
        // zeros, subnormals, infinities, nans
        send_modes(32'h0000_0000, 32'h4049_0fdb);
        send_modes(32'h8000_0000, 32'h3f80_0000);
        send_modes(32'h0000_0001, 32'hc000_0000);
        send_modes(32'h7f80_0000, 32'hc000_0000);
        send_modes(32'hff80_0000, 32'h7f80_0000);
        send_modes(32'h7f80_0000, 32'h0000_0000);
        send_modes(32'h007f_ffff, 32'hff80_0000);
        send_modes(32'h7fc1_2345, 32'h3f80_0000);
        send_modes(32'h3f80_0000, 32'hffa0_0000);
        // exponent limits
        send_modes(32'h7f00_0000, 32'h7f00_0000);
        send_modes(32'hff7f_ffff, 32'h4000_0000);
        send_modes(32'h0080_0000, 32'h0080_0000);
        send_modes(32'h0080_0000, 32'h3f7f_ffff);
        send_modes(32'h0080_0000, 32'h3f80_0000);
        send_modes(32'h7f7f_ffff, 32'h3f80_0000);
        send_modes(32'h7f00_0000, 32'h3fff_ffff);
        // all-ones fraction that carries into the exponent
        send_modes(32'h3fff_fffe, 32'h3f80_0001);
        send_modes(32'hbfff_fffe, 32'h3f80_0001);
        send_modes(32'h7f7f_fffe, 32'h3f80_0001);
        drain();

        stall_en = 1'b1;
        for (int i = 0; i < 300; i++) begin
            send($random(seed), $random(seed), 3'($random(seed)));
        end
        drain();
        stall_en = 1'b0;
        next_cycle();
        next_cycle();

        // nothing may be left in flight once every result has arrived
        assert (!out_valid && n_in == n_out) else begin
            $display("pipeline still holds a result, %0d results for %0d inputs", n_out, n_in);
            stop_on_error();
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

/* sim.f */
fp_format_pkg.sv
fp_mul_pkg.sv
fp_stage_if.sv
fp_pipe_reg.sv
fp_frac_mul.sv
fp_exp_pack.sv
fp_norm_round.sv
fp_mul_checker.sv
fp_mul_top.sv
tb_fp_mul.sv

/* run_sim.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_fp_mul -f sim.f \
    -o tb_fp_mul > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_fp_mul > sim.log 2>&1
cat sim.log
grep -q "^Simulation passed$" sim.log && exit 0 || exit 1
